// ==== tb.f ====
src/rvPkg.sv
src/busReqUnit.sv
src/instrDecoder.sv
src/aluUnit.sv
src/regFile.sv
src/cpuCore.sv
src/cpuTop.sv
tests/busMemModel.sv
tests/tbTop.sv

// ==== Makefile ====
# Verilator build and run for the RV32I subset core testbench

VERILATOR ?= verilator
TOP       ?= tbTop
RTL_TOP   ?= cpuTop
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: default build run lint clean

default: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tbTop.sv ====
// Testbench for the RV32I subset core that checks bus traffic against an instruction-level model
`timescale 1ns/1ps

module tbTop;

  localparam int MAX_BUSY         = 4;
  localparam int CYCLES_PER_INSTR = 200;

  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI,
    K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_JALR
  } kind_e;

  logic           clk = 1'b0;
  logic           rstN;
  rvPkg::busReq_t busReq;
  rvPkg::busRsp_t busRsp;

  kind_e       pKind [0:255];
  logic [4:0]  pRd [0:255];
  logic [4:0]  pRs1 [0:255];
  logic [4:0]  pRs2 [0:255];
  logic [31:0] pImm [0:255];
  logic [31:0] progWord [0:255];
  logic [31:0] modelMem [0:255];
  int          progLen = 0;
  logic [31:0] expReads [$];
  logic [63:0] expWrites [$];
  logic [31:0] finalPc;
  logic [31:0] expAddr;
  logic [63:0] expWrite;
  int          mismatchCount = 0;
  int          protocolCount = 0;
  logic        done = 1'b0;
  logic        reqNow;
  logic        startNow;
  logic        completeNow;
  logic        prevReq = 1'b0;
  logic        prevComplete = 1'b0;
  logic        busySeen = 1'b0;
  logic [31:0] prevAddr;
  logic [31:0] prevWdata;

  always #4 clk = ~clk;

  cpuTop i_cpuTop (
    .clk_i    (clk),
    .rstN_i   (rstN),
    .busRsp_i (busRsp),
    .busReq_o (busReq)
  );

  busMemModel i_busMemModel (
    .clk_i    (clk),
    .rstN_i   (rstN),
    .busReq_i (busReq),
    .busRsp_o (busRsp)
  );

  // RV32I instruction formats
  function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic addInstr(kind_e k, logic [4:0] d, logic [4:0] s1, logic [4:0] s2,
                          logic [31:0] im);
    logic [31:0] w;
    logic [7:0]  idx;
    case (k)
      K_ADD:   w = encR(7'h00, s2, s1, 3'b000, d);
      K_SUB:   w = encR(7'h20, s2, s1, 3'b000, d);
      K_AND:   w = encR(7'h00, s2, s1, 3'b111, d);
      K_OR:    w = encR(7'h00, s2, s1, 3'b110, d);
      K_XOR:   w = encR(7'h00, s2, s1, 3'b100, d);
      K_SLT:   w = encR(7'h00, s2, s1, 3'b010, d);
      K_ADDI:  w = encI(im, s1, 3'b000, d, 7'b0010011);
      K_LUI:   w = {im[31:12], d, 7'b0110111};
      K_LW:    w = encI(im, s1, 3'b010, d, 7'b0000011);
      K_SW:    w = encS(im, s2, s1);
      K_BEQ:   w = encB(im, s2, s1, 3'b000);
      K_BNE:   w = encB(im, s2, s1, 3'b001);
      K_JAL:   w = encJ(im, d);
      default: w = encI(im, s1, 3'b000, d, 7'b1100111);
    endcase
    idx = progLen[7:0];
    pKind[idx]    = k;
    pRd[idx]      = d;
    pRs1[idx]     = s1;
    pRs2[idx]     = s2;
    pImm[idx]     = im;
    progWord[idx] = w;
    progLen++;
  endtask

  task automatic buildProgram();
    addInstr(K_ADDI, 1, 0, 0, 100);
    addInstr(K_ADDI, 2, 0, 0, -7);
    addInstr(K_ADD, 3, 1, 2, 0);
    addInstr(K_SW, 0, 0, 3, 32'h200);
    addInstr(K_SUB, 4, 2, 1, 0);
    addInstr(K_SW, 0, 0, 4, 32'h204);
    addInstr(K_AND, 5, 1, 2, 0);
    addInstr(K_SW, 0, 0, 5, 32'h208);
    addInstr(K_OR, 6, 1, 2, 0);
    addInstr(K_SW, 0, 0, 6, 32'h20C);
    addInstr(K_XOR, 7, 1, 2, 0);
    addInstr(K_SW, 0, 0, 7, 32'h210);
    addInstr(K_SLT, 8, 2, 1, 0);
    addInstr(K_SW, 0, 0, 8, 32'h214);
    addInstr(K_LUI, 10, 0, 0, 32'hABCD_E000);
    addInstr(K_SW, 0, 0, 10, 32'h218);
    // Reload a stored word and copy it
    addInstr(K_LW, 11, 0, 0, 32'h200);
    addInstr(K_SW, 0, 0, 11, 32'h21C);
    addInstr(K_ADDI, 0, 0, 0, 55);
    addInstr(K_SW, 0, 0, 0, 32'h220);
    addInstr(K_BEQ, 0, 1, 1, 8);
    addInstr(K_SW, 0, 0, 1, 32'h224);
    addInstr(K_BNE, 0, 1, 1, 8);
    addInstr(K_BNE, 0, 1, 2, 8);
    addInstr(K_SW, 0, 0, 1, 32'h228);
    addInstr(K_BEQ, 0, 1, 2, 8);
    addInstr(K_JAL, 12, 0, 0, 8);
    addInstr(K_SW, 0, 0, 1, 32'h22C);
    addInstr(K_SW, 0, 0, 12, 32'h230);
    addInstr(K_ADDI, 13, 0, 0, 132);
    // Odd target so bit 0 is dropped
    addInstr(K_JALR, 14, 13, 0, 1);
    addInstr(K_SW, 0, 0, 1, 32'h234);
    addInstr(K_SW, 0, 0, 1, 32'h238);
    addInstr(K_SW, 0, 0, 14, 32'h23C);
    addInstr(K_JAL, 0, 0, 0, 0);
  endtask

  task automatic loadMemory();
    logic [7:0]  idx;
    logic [31:0] addr;
    for (int i = 0; i < 256; i++) begin
      idx  = i[7:0];
      addr = {22'b0, idx, 2'b00};
      i_busMemModel.mem[idx] = (i < progLen) ? progWord[idx] : (32'h5A00_0000 ^ addr);
      modelMem[idx] = i_busMemModel.mem[idx];
    end
  endtask

  // Instruction-level reference that records expected bus reads and writes
  task automatic runModel();
    logic [31:0] r [0:31];
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [7:0]  i;
    logic        stop;
    for (int n = 0; n < 32; n++) begin
      r[n] = '0;
    end
    pc   = '0;
    stop = 1'b0;
    while (!stop) begin
      i    = pc[9:2];
      a    = r[pRs1[i]];
      b    = r[pRs2[i]];
      ea   = a + pImm[i];
      next = pc + 32'd4;
      expReads.push_back(pc);
      if (pKind[i] == K_JAL && pImm[i] == '0) begin
        finalPc = pc;
        stop    = 1'b1;
      end
      case (pKind[i])
        K_ADD:  r[pRd[i]] = a + b;
        K_SUB:  r[pRd[i]] = a - b;
        K_AND:  r[pRd[i]] = a & b;
        K_OR:   r[pRd[i]] = a | b;
        K_XOR:  r[pRd[i]] = a ^ b;
        K_SLT:  r[pRd[i]] = {31'b0, $signed(a) < $signed(b)};
        K_ADDI: r[pRd[i]] = ea;
        K_LUI:  r[pRd[i]] = pImm[i];
        K_LW: begin
          expReads.push_back(ea);
          r[pRd[i]] = modelMem[ea[9:2]];
        end
        K_SW: begin
          expWrites.push_back({ea, b});
          modelMem[ea[9:2]] = b;
        end
        K_BEQ:  next = (a == b) ? pc + pImm[i] : next;
        K_BNE:  next = (a != b) ? pc + pImm[i] : next;
        K_JAL: begin
          r[pRd[i]] = pc + 32'd4;
          next      = pc + pImm[i];
        end
        default: begin
          r[pRd[i]] = pc + 32'd4;
          next      = {ea[31:1], 1'b0};
        end
      endcase
      r[0] = '0;
      pc   = next;
    end
  endtask

  task automatic checkBusWrite();
    if (expWrites.size() == 0) begin
      protocolCount++;
      $display("Bus write to %h that the program does not make", busReq.addr);
    end else begin
      expWrite = expWrites.pop_front();
      assert (busReq.addr == expWrite[63:32]) else begin
        mismatchCount++;
        $display("MISMATCH busReq_o.addr: got %h, expected %h", busReq.addr, expWrite[63:32]);
      end
      assert (busReq.wdata == expWrite[31:0]) else begin
        mismatchCount++;
        $display("MISMATCH busReq_o.wdata: got %h, expected %h", busReq.wdata, expWrite[31:0]);
      end
    end
  endtask

  task automatic checkBusRead();
    if (expReads.size() != 0) begin
      expAddr = expReads.pop_front();
      assert (busReq.addr == expAddr) else begin
        mismatchCount++;
        $display("MISMATCH busReq_o.addr: got %h, expected %h", busReq.addr, expAddr);
      end
    end else if (busReq.addr == finalPc) begin
      done = 1'b1;
    end else begin
      protocolCount++;
      $display("Read from %h after the program reached its final loop", busReq.addr);
    end
  endtask

  assert property (@(posedge clk) disable iff (!rstN) !(busReq.read && busReq.write))
    else begin
      protocolCount++;
      $display("Read and write were high together at %0t", $time);
    end

  always @(posedge clk) begin
    reqNow      = busReq.read || busReq.write;
    startNow    = reqNow && !prevReq;
    completeNow = reqNow && busySeen && !busRsp.busy;
    if (!rstN) begin
      assert (!reqNow) else begin
        protocolCount++;
        $display("Bus request active during reset");
      end
    end else begin
      if (prevComplete) begin
        assert (!reqNow) else begin
          protocolCount++;
          $display("Request was not dropped in the cycle after completion");
        end
      end else if (prevReq && reqNow) begin
        assert (busReq.addr == prevAddr) else begin
          mismatchCount++;
          $display("MISMATCH busReq_o.addr: moved to %h from %h", busReq.addr, prevAddr);
        end
        assert (busReq.wdata == prevWdata) else begin
          mismatchCount++;
          $display("MISMATCH busReq_o.wdata: moved to %h from %h", busReq.wdata, prevWdata);
        end
      end
      if (startNow && busReq.write) begin
        checkBusWrite();
      end
      if (startNow && busReq.read) begin
        checkBusRead();
      end
    end
    busySeen     = reqNow && (busySeen || busRsp.busy) && !completeNow;
    prevReq      = reqNow;
    prevComplete = completeNow;
    prevAddr     = busReq.addr;
    prevWdata    = busReq.wdata;
  end

  initial begin
    rstN = 1'b0;
    buildProgram();
    loadMemory();
    runModel();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    wait (done);
    @(posedge clk);
    if (expWrites.size() != 0) begin
      protocolCount++;
      $display("%0d expected bus writes never appeared", expWrites.size());
    end
    $display("Errors: %0d mismatch, %0d protocol", mismatchCount, protocolCount);
    if (mismatchCount + protocolCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog scaled by program length and worst busy length
  initial begin
    wait (progLen > 0);
    repeat (progLen * CYCLES_PER_INSTR * MAX_BUSY) @(posedge clk);
    $display("Timeout, the core never reached the final loop");
    $display("Errors: %0d mismatch, %0d protocol", mismatchCount, protocolCount);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tests/busMemModel.sv ====
// Testbench word memory that answers busy-handshake bus requests with varying busy lengths
`timescale 1ns/1ps

module busMemModel (
  input  logic           clk_i,
  input  logic           rstN_i,
  input  rvPkg::busReq_t busReq_i,
  output rvPkg::busRsp_t busRsp_o
);

  logic [31:0] mem [0:255];
  logic [31:0] lfsr = 32'h9348_3458;
  logic        active;
  logic        dropWait;
  logic [1:0]  count;

  // Fibonacci LFSR with taps 32 22 2 1 and one bit per call
  function logic lfsrBit();
    lfsrBit = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr    = {lfsr[30:0], lfsrBit};
  endfunction

  always @(posedge clk_i or negedge rstN_i) begin
    logic b0;
    logic b1;
    if (!rstN_i) begin
      active   <= 1'b0;
      dropWait <= 1'b0;
      count    <= 2'd0;
      busRsp_o <= '0;
    end else if (dropWait) begin
      // Request still visible in the completion cycle
      dropWait <= 1'b0;
    end else if (active) begin
      if (count == 2'd0) begin
        busRsp_o.busy  <= 1'b0;
        busRsp_o.rdata <= mem[busReq_i.addr[9:2]];
        if (busReq_i.write) begin
          mem[busReq_i.addr[9:2]] = busReq_i.wdata;
        end
        active   <= 1'b0;
        dropWait <= 1'b1;
      end else begin
        count <= count - 2'd1;
      end
    end else if (busReq_i.read || busReq_i.write) begin
      // Busy length of one to four cycles
      b0 = lfsrBit();
      b1 = lfsrBit();
      active        <= 1'b1;
      busRsp_o.busy <= 1'b1;
      count         <= {b1, b0};
    end
  end

endmodule

// ==== src/cpuTop.sv ====
// Processor top level, joins the core to the request unit and the memory bus
`timescale 1ns/1ps

module cpuTop (
  input  logic           clk_i,
  input  logic           rstN_i,
  input  rvPkg::busRsp_t busRsp_i,
  output rvPkg::busReq_t busReq_o
);

  rvPkg::memReq_t memReq;
  rvPkg::memRsp_t memRsp;

  // Processing side
  cpuCore i_cpuCore (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .memRsp_i (memRsp),
    .memReq_o (memReq)
  );

  // Fetch, load and store traffic onto the bus
  busReqUnit i_busReqUnit (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .memReq_i (memReq),
    .memRsp_o (memRsp),
    .busRsp_i (busRsp_i),
    .busReq_o (busReq_o)
  );

endmodule

// ==== src/cpuCore.sv ====
// Multi-cycle core, runs fetch, execute and memory phases one instruction at a time
`timescale 1ns/1ps

module cpuCore (
  input  logic           clk_i,
  input  logic           rstN_i,
  input  rvPkg::memRsp_t memRsp_i,
  output rvPkg::memReq_t memReq_o
);

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    MEM
  } coreState_t;

  coreState_t   state;
  rvPkg::word_t pc;
  rvPkg::word_t instrReg;
  rvPkg::ctrl_t ctrl;
  rvPkg::word_t rdata1;
  rvPkg::word_t rdata2;
  rvPkg::word_t aluB;
  rvPkg::word_t aluResult;
  rvPkg::word_t pcPlus4;
  rvPkg::word_t nextPc;
  rvPkg::word_t wbData;
  logic         equal;
  logic         isMem;
  logic         branchTaken;
  logic         regWe;

  instrDecoder i_instrDecoder (
    .instr_i (instrReg),
    .ctrl_o  (ctrl)
  );

  regFile i_regFile (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .we_i     (regWe),
    .rs1_i    (ctrl.rs1),
    .rs2_i    (ctrl.rs2),
    .rd_i     (ctrl.rd),
    .wdata_i  (wbData),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  assign aluB = ctrl.useImm ? ctrl.imm : rdata2;

  aluUnit i_aluUnit (
    .aluOp_i  (ctrl.aluOp),
    .opA_i    (rdata1),
    .opB_i    (aluB),
    .result_o (aluResult),
    .equal_o  (equal)
  );

  assign isMem       = ctrl.memRead | ctrl.memWrite;
  assign pcPlus4     = pc + 32'd4;
  assign branchTaken = ctrl.branch && (equal ^ ctrl.branchNe);

  // Next PC chosen in EXEC
  always_comb begin
    if (ctrl.jalr) begin
      nextPc = {aluResult[31:1], 1'b0};
    end else if (ctrl.jal || branchTaken) begin
      nextPc = pc + ctrl.imm;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // Writeback source and enable
  assign wbData = ctrl.memRead ? memRsp_i.rdata :
                  (ctrl.jal || ctrl.jalr) ? pcPlus4 : aluResult;
  assign regWe  = ctrl.regWrite &&
                  (((state == EXEC) && !isMem) || ((state == MEM) && memRsp_i.dhit));

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state <= FETCH;
      pc    <= rvPkg::RESET_PC;
    end else begin
      case (state)
        FETCH: begin
          if (memRsp_i.ihit) begin
            state <= EXEC;
          end
        end
        EXEC: begin
          if (isMem) begin
            state <= MEM;
          end else begin
            pc    <= nextPc;
            state <= FETCH;
          end
        end
        MEM: begin
          if (memRsp_i.dhit) begin
            pc    <= pcPlus4;
            state <= FETCH;
          end
        end
        default: state <= FETCH;
      endcase
    end
  end

  // Instruction latched on the fetch hit
  always_ff @(posedge clk_i) begin
    if ((state == FETCH) && memRsp_i.ihit) begin
      instrReg <= memRsp_i.rdata;
    end
  end

  always_comb begin
    memReq_o.instrRead = (state == FETCH);
    memReq_o.dataRead  = (state == MEM) && ctrl.memRead;
    memReq_o.dataWrite = (state == MEM) && ctrl.memWrite;
    memReq_o.dataAddr  = aluResult;
    memReq_o.writeData = rdata2;
    memReq_o.pc        = pc;
  end

endmodule

// ==== src/regFile.sv ====
// Register file with x0 tied to zero, two read ports and one write port
`timescale 1ns/1ps

module regFile (
  input  logic           clk_i,
  input  logic           rstN_i,
  input  logic           we_i,
  input  rvPkg::regIdx_t rs1_i,
  input  rvPkg::regIdx_t rs2_i,
  input  rvPkg::regIdx_t rd_i,
  input  rvPkg::word_t   wdata_i,
  output rvPkg::word_t   rdata1_o,
  output rvPkg::word_t   rdata2_o
);

  // x1..x31 only
  rvPkg::word_t regs [1:31];

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== src/aluUnit.sv ====
// ALU for the RV32I subset, with operand equality for branches
`timescale 1ns/1ps

module aluUnit (
  input  rvPkg::aluOp_t aluOp_i,
  input  rvPkg::word_t  opA_i,
  input  rvPkg::word_t  opB_i,
  output rvPkg::word_t  result_o,
  output logic          equal_o
);

  logic lessSigned;

  // Signed compare for SLT
  assign lessSigned = $signed(opA_i) < $signed(opB_i);

  always_comb begin
    case (aluOp_i)
      rvPkg::ALU_ADD: begin
        result_o = opA_i + opB_i;
      end
      rvPkg::ALU_SUB: begin
        result_o = opA_i - opB_i;
      end
      rvPkg::ALU_AND: begin
        result_o = opA_i & opB_i;
      end
      rvPkg::ALU_OR: begin
        result_o = opA_i | opB_i;
      end
      rvPkg::ALU_XOR: begin
        result_o = opA_i ^ opB_i;
      end
      rvPkg::ALU_SLT: begin
        result_o = {31'b0, lessSigned};
      end
      rvPkg::ALU_PASSB: begin
        result_o = opB_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

  // BEQ/BNE condition
  assign equal_o = (opA_i == opB_i);

endmodule

// ==== src/instrDecoder.sv ====
// Instruction decoder, turns an RV32I subset word into control fields and immediate
`timescale 1ns/1ps

module instrDecoder (
  input  rvPkg::word_t instr_i,
  output rvPkg::ctrl_t ctrl_o
);

  rvPkg::opcode_t opcode;
  logic [2:0]     funct3;
  logic           bit30;
  rvPkg::word_t   immI;
  rvPkg::word_t   immS;
  rvPkg::word_t   immB;
  rvPkg::word_t   immU;
  rvPkg::word_t   immJ;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign bit30  = instr_i[30];

  // Sign-extended immediates per format
  assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
  assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                 instr_i[11:8], 1'b0};
  assign immU = {instr_i[31:12], 12'b0};
  assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                 instr_i[30:21], 1'b0};

  always_comb begin
    // No-op unless a known encoding turns something on
    ctrl_o       = '0;
    ctrl_o.aluOp = rvPkg::ALU_ADD;
    ctrl_o.imm   = immI;
    ctrl_o.rs1   = instr_i[19:15];
    ctrl_o.rs2   = instr_i[24:20];
    ctrl_o.rd    = instr_i[11:7];

    case (opcode)
      rvPkg::OP_RTYPE: begin
        ctrl_o.regWrite = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.aluOp = bit30 ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
          3'b010:  ctrl_o.aluOp = rvPkg::ALU_SLT;
          3'b100:  ctrl_o.aluOp = rvPkg::ALU_XOR;
          3'b110:  ctrl_o.aluOp = rvPkg::ALU_OR;
          3'b111:  ctrl_o.aluOp = rvPkg::ALU_AND;
          default: ctrl_o.regWrite = 1'b0;
        endcase
      end
      rvPkg::OP_ITYPE: begin
        // ADDI only
        ctrl_o.useImm   = 1'b1;
        ctrl_o.regWrite = (funct3 == 3'b000);
      end
      rvPkg::OP_LUI: begin
        ctrl_o.aluOp    = rvPkg::ALU_PASSB;
        ctrl_o.useImm   = 1'b1;
        ctrl_o.imm      = immU;
        ctrl_o.regWrite = 1'b1;
      end
      rvPkg::OP_LOAD: begin
        ctrl_o.useImm   = 1'b1;
        ctrl_o.memRead  = (funct3 == 3'b010);
        ctrl_o.regWrite = (funct3 == 3'b010);
      end
      rvPkg::OP_STORE: begin
        ctrl_o.useImm   = 1'b1;
        ctrl_o.imm      = immS;
        ctrl_o.memWrite = (funct3 == 3'b010);
      end
      rvPkg::OP_BRANCH: begin
        // BEQ and BNE, compared on rs1 and rs2
        ctrl_o.imm      = immB;
        ctrl_o.branch   = (funct3[2:1] == 2'b00);
        ctrl_o.branchNe = funct3[0];
      end
      rvPkg::OP_JAL: begin
        ctrl_o.imm      = immJ;
        ctrl_o.jal      = 1'b1;
        ctrl_o.regWrite = 1'b1;
      end
      rvPkg::OP_JALR: begin
        ctrl_o.useImm   = 1'b1;
        ctrl_o.jalr     = (funct3 == 3'b000);
        ctrl_o.regWrite = (funct3 == 3'b000);
      end
      default: begin
        ctrl_o.regWrite = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/busReqUnit.sv ====
// Bus request unit, places fetch and data accesses on the busy-handshake memory bus
`timescale 1ns/1ps

module busReqUnit (
  input  logic           clk_i,
  input  logic           rstN_i,
  input  rvPkg::memReq_t memReq_i,
  output rvPkg::memRsp_t memRsp_o,
  input  rvPkg::busRsp_t busRsp_i,
  output rvPkg::busReq_t busReq_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAITBUSY
  } ruState_t;

  ruState_t     state;
  ruState_t     stateNext;
  logic         reqRead;
  logic         reqWrite;
  logic         reqData;
  rvPkg::word_t reqAddr;
  rvPkg::word_t reqWdata;
  logic         dataPending;
  logic         start;
  logic         complete;

  // Data side wins if both were pending
  assign dataPending = memReq_i.dataRead | memReq_i.dataWrite;
  assign start       = (state == IDLE) && (dataPending || memReq_i.instrRead);
  // First low busy after busy was seen high
  assign complete    = (state == WAITBUSY) && !busRsp_i.busy;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (start) begin
          stateNext = REQUEST;
        end
      end
      REQUEST: begin
        if (busRsp_i.busy) begin
          stateNext = WAITBUSY;
        end
      end
      WAITBUSY: begin
        if (complete) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state    <= IDLE;
      reqRead  <= 1'b0;
      reqWrite <= 1'b0;
      reqData  <= 1'b0;
    end else begin
      state <= stateNext;
      if (start) begin
        reqRead  <= !memReq_i.dataWrite;
        reqWrite <= memReq_i.dataWrite;
        reqData  <= dataPending;
      end else if (complete) begin
        // Request drops the cycle after completion
        reqRead  <= 1'b0;
        reqWrite <= 1'b0;
      end
    end
  end

  // Address and write data held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (start) begin
      reqAddr  <= dataPending ? memReq_i.dataAddr : memReq_i.pc;
      reqWdata <= memReq_i.writeData;
    end
  end

  always_comb begin
    busReq_o.read  = reqRead;
    busReq_o.write = reqWrite;
    busReq_o.addr  = reqAddr;
    busReq_o.wdata = reqWdata;
    memRsp_o.ihit  = complete && !reqData;
    memRsp_o.dhit  = complete && reqData;
    memRsp_o.rdata = busRsp_i.rdata;
  end

endmodule

// ==== src/rvPkg.sv ====
// RV32I subset core package with shared widths, codes and interface structs
package rvPkg;

  // Meaningful widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [3:0]  aluOp_t;
  typedef logic [6:0]  opcode_t;

  // Fetch starts here after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // ALU operation codes
  localparam aluOp_t ALU_ADD   = 4'd0;
  localparam aluOp_t ALU_SUB   = 4'd1;
  localparam aluOp_t ALU_AND   = 4'd2;
  localparam aluOp_t ALU_OR    = 4'd3;
  localparam aluOp_t ALU_XOR   = 4'd4;
  localparam aluOp_t ALU_SLT   = 4'd5;
  localparam aluOp_t ALU_PASSB = 4'd6;

  // Major opcodes of the supported subset
  localparam opcode_t OP_RTYPE  = 7'b0110011;
  localparam opcode_t OP_ITYPE  = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

  // Decoded control, 59 bits
  typedef struct packed {
    aluOp_t  aluOp;
    logic    useImm;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    branch;
    logic    branchNe;
    logic    jal;
    logic    jalr;
    word_t   imm;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
  } ctrl_t;

  // Core to request unit
  typedef struct packed {
    logic  instrRead;
    logic  dataRead;
    logic  dataWrite;
    word_t dataAddr;
    word_t writeData;
    word_t pc;
  } memReq_t;

  // Request unit to core
  typedef struct packed {
    logic  ihit;
    logic  dhit;
    word_t rdata;
  } memRsp_t;

  // Master side of the memory bus
  typedef struct packed {
    logic  read;
    logic  write;
    word_t addr;
    word_t wdata;
  } busReq_t;

  // Slave side of the memory bus
  typedef struct packed {
    logic  busy;
    word_t rdata;
  } busRsp_t;

endpackage
